/* decode.sv */
// Decode stage with instruction decoder, eight-entry register file and illegal-opcode error
`timescale 1ns/1ps
`default_nettype none

module decode (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic [procPkg::dataWidth-1:0] instr,
    input  logic [procPkg::dataWidth-1:0] writeData,
    input  logic                          halted,
    execBus.decoder                       bus,
    output logic                          halt,
    output logic                          err
);
    import procPkg::*;

    opcodeT                  opcode;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] rd;
    logic [regAddrWidth-1:0] dest;
    logic                    illegal;
    ctrlT                    ctrl;
    logic [dataWidth-1:0]    regs [numRegs];

    assign opcode = opcodeT'(instr[opcodeLsb +: opcodeWidth]);
    assign rs     = instr[rsLsb +: regAddrWidth];
    assign rt     = instr[rtLsb +: regAddrWidth];
    assign rd     = instr[rdLsb +: regAddrWidth];

    always_comb begin
        ctrl    = ctrlIdle;
        illegal = 1'b0;
        dest    = rd;
        case (opcode)
            opAlu: begin
                ctrl.aluFunc  = aluFuncT'(instr[1:0]);
                ctrl.regWrite = 1'b1;
            end
            opAddi: begin
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
                dest          = rt;
            end
            opSeq: begin
                ctrl.setEq    = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opSlt: begin
                ctrl.setLt    = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opLd: begin
                ctrl.useImm   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                dest          = rt;
            end
            opSt: begin
                ctrl.useImm   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            opBeqz: begin
                ctrl.nextPcSel    = pcBranch;
                ctrl.branchOnZero = 1'b1;
            end
            opBnez: ctrl.nextPcSel = pcBranch;
            opJ: ctrl.nextPcSel = pcJump;
            opJr: ctrl.nextPcSel = pcJumpReg;
            opHalt: ctrl = ctrlIdle;
            default: illegal = 1'b1;
        endcase
        // Nothing commits once the core has stopped
        if (halted) begin
            ctrl = ctrlIdle;
        end
    end

    assign halt = (opcode == opHalt) && !halted;
    assign err  = illegal && !halted;

    // Register 0 is an ordinary register here
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (bus.regWrite) begin
            regs[bus.destReg] <= writeData;
        end
    end

    assign bus.opA          = regs[rs];
    assign bus.opB          = regs[rt];
    assign bus.imm          = immOf(instr);
    assign bus.useImm       = ctrl.useImm;
    assign bus.aluFunc      = ctrl.aluFunc;
    assign bus.setEq        = ctrl.setEq;
    assign bus.setLt        = ctrl.setLt;
    assign bus.nextPcSel    = ctrl.nextPcSel;
    assign bus.branchOnZero = ctrl.branchOnZero;
    assign bus.memRead      = ctrl.memRead;
    assign bus.memWrite     = ctrl.memWrite;
    assign bus.memToReg     = ctrl.memToReg;
    assign bus.regWrite     = ctrl.regWrite;
    assign bus.destReg      = dest;

    assert property (@(posedge clk) disable iff (!rstN)
        !(bus.memRead && bus.memWrite))
        else $error("decode: load and store decoded together");

    assert property (@(posedge clk) disable iff (!rstN)
        !(err && bus.regWrite))
        else $error("decode: illegal instruction writes a register");

endmodule

`default_nettype wire

/* execBus.sv */
// Decode-to-execute/memory bus interface with decoder, alu and mem modports
`timescale 1ns/1ps
`default_nettype none

interface execBus;
    import procPkg::*;

    logic [dataWidth-1:0]    opA;
    logic [dataWidth-1:0]    opB;
    logic [dataWidth-1:0]    imm;
    logic                    useImm;
    aluFuncT                 aluFunc;
    logic                    setEq;
    logic                    setLt;
    nextPcSelT               nextPcSel;
    logic                    branchOnZero;
    logic                    memRead;
    logic                    memWrite;
    logic                    memToReg;
    logic                    regWrite;
    logic [regAddrWidth-1:0] destReg;

    modport decoder (
        output opA, opB, imm, useImm, aluFunc, setEq, setLt, nextPcSel,
               branchOnZero, memRead, memWrite, memToReg, regWrite, destReg
    );

    modport alu (
        input opA, opB, imm, useImm, aluFunc, setEq, setLt, nextPcSel, branchOnZero
    );

    // Store data comes from the second operand
    modport mem (
        input opB, memRead, memWrite, memToReg
    );

endinterface

`default_nettype wire

/* execute.sv */
// Execute stage with ALU, set compares and next-PC selection for branches and jumps
`timescale 1ns/1ps
`default_nettype none

module execute (
    execBus.alu                           bus,
    input  logic [procPkg::dataWidth-1:0] incPc,
    output logic [procPkg::dataWidth-1:0] aluResult,
    output logic [procPkg::dataWidth-1:0] nextPc
);
    import procPkg::*;

    logic [dataWidth-1:0] srcB;
    logic [dataWidth-1:0] aluOut;
    logic                 opAIsZero;
    logic                 branchTaken;
    logic [dataWidth-1:0] relTarget;

    // Immediate forms replace the second register
    assign srcB = bus.useImm ? bus.imm : bus.opB;

    // Arithmetic wraps at the word width
    always_comb begin
        case (bus.aluFunc)
            funcAdd: aluOut = bus.opA + srcB;
            funcSub: aluOut = bus.opA - srcB;
            funcAnd: aluOut = bus.opA & srcB;
            funcXor: aluOut = bus.opA ^ srcB;
            default: aluOut = '0;
        endcase
    end

    // Set results are 1 or 0 with a signed less-than
    always_comb begin
        if (bus.setEq) begin
            aluResult = dataWidth'(bus.opA == bus.opB);
        end else if (bus.setLt) begin
            aluResult = dataWidth'($signed(bus.opA) < $signed(bus.opB));
        end else begin
            aluResult = aluOut;
        end
    end

    assign opAIsZero   = (bus.opA == '0);
    assign branchTaken = bus.branchOnZero ? opAIsZero : !opAIsZero;
    assign relTarget   = incPc + bus.imm;

    always_comb begin
        case (bus.nextPcSel)
            pcSeq:     nextPc = incPc;
            pcBranch:  nextPc = branchTaken ? relTarget : incPc;
            pcJump:    nextPc = relTarget;
            pcJumpReg: nextPc = bus.opA;
            default:   nextPc = incPc;
        endcase
    end

endmodule

`default_nettype wire

/* fetch.sv */
// Fetch stage with program counter, instruction memory and halt hold
`timescale 1ns/1ps
`default_nettype none

module fetch (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic [procPkg::dataWidth-1:0] nextPc,
    input  logic                         halt,
    output logic [procPkg::dataWidth-1:0] instr,
    output logic [procPkg::dataWidth-1:0] incPc,
    output logic                         halted
);
    import procPkg::*;

    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] imem [imemDepth];

    initial begin
        $readmemh(programFile, imem);
    end

    // PC freezes on the halt instruction itself
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc     <= '0;
            halted <= 1'b0;
        end else begin
            if (halt) begin
                halted <= 1'b1;
            end
            if (!halt && !halted) begin
                pc <= nextPc;
            end
        end
    end

    // Word addressed so the next PC is one past the current one
    assign instr = imem[pc[imemAddrWidth-1:0]];
    assign incPc = pc + dataWidth'(1);

    assert property (@(posedge clk) disable iff (!rstN)
        halted |=> $stable(pc))
        else $error("fetch: PC moved while halted");

endmodule

`default_nettype wire

/* memoryStage.sv */
// Memory stage with data memory and register write-back selection
`timescale 1ns/1ps
`default_nettype none

module memoryStage (
    input  logic                          clk,
    input  logic                          rstN,
    execBus.mem                           bus,
    input  logic [procPkg::dataWidth-1:0] aluResult,
    output logic [procPkg::dataWidth-1:0] writeData,
    output logic                          memWriteEn,
    output logic [procPkg::dataWidth-1:0] memAddr,
    output logic [procPkg::dataWidth-1:0] memWriteData
);
    import procPkg::*;

    logic [dataWidth-1:0]     dmem [dmemDepth];
    logic [dmemAddrWidth-1:0] wordIdx;
    logic [dataWidth-1:0]     readData;

    initial begin
        for (int i = 0; i < dmemDepth; i++) begin
            dmem[i] = '0;
        end
    end

    // Word addressed by the low bits of the ALU result
    assign wordIdx = aluResult[dmemAddrWidth-1:0];

    always_ff @(posedge clk) begin
        if (bus.memWrite) begin
            dmem[wordIdx] <= bus.opB;
        end
    end

    assign readData = dmem[wordIdx];

    // Write-back select between the loaded word and the ALU result
    assign writeData = bus.memToReg ? readData : aluResult;

    assign memWriteEn   = bus.memWrite;
    assign memAddr      = aluResult;
    assign memWriteData = bus.opB;

    assert property (@(posedge clk) disable iff (!rstN)
        (bus.memRead || bus.memWrite) |-> (aluResult < dataWidth'(dmemDepth)))
        else $error("memoryStage: address %0h outside data memory", aluResult);

endmodule

`default_nettype wire

/* proc.sv */
// Processor top level connecting the stages and driving the retire trace ports
`timescale 1ns/1ps
`default_nettype none

module proc (
    input  logic                             clk,
    input  logic                             rstN,
    output logic                             err,
    output logic                             halted,
    output logic                             retireValid,
    output logic                             regWriteEn,
    output logic [procPkg::regAddrWidth-1:0] regWriteAddr,
    output logic [procPkg::dataWidth-1:0]    regWriteData,
    output logic                             memWriteEn,
    output logic [procPkg::dataWidth-1:0]    memAddr,
    output logic [procPkg::dataWidth-1:0]    memWriteData
);
    import procPkg::*;

    logic [dataWidth-1:0] instr;
    logic [dataWidth-1:0] incPc;
    logic [dataWidth-1:0] nextPc;
    logic [dataWidth-1:0] aluResult;
    logic [dataWidth-1:0] writeData;
    logic                 halt;

    execBus u_bus ();

    fetch u_fetch (
        .clk    (clk),
        .rstN   (rstN),
        .nextPc (nextPc),
        .halt   (halt),
        .instr  (instr),
        .incPc  (incPc),
        .halted (halted)
    );

    decode u_decode (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .writeData (writeData),
        .halted    (halted),
        .bus       (u_bus.decoder),
        .halt      (halt),
        .err       (err)
    );

    execute u_execute (
        .bus       (u_bus.alu),
        .incPc     (incPc),
        .aluResult (aluResult),
        .nextPc    (nextPc)
    );

    memoryStage u_memory (
        .clk          (clk),
        .rstN         (rstN),
        .bus          (u_bus.mem),
        .aluResult    (aluResult),
        .writeData    (writeData),
        .memWriteEn   (memWriteEn),
        .memAddr      (memAddr),
        .memWriteData (memWriteData)
    );

    // Trace shows the instruction that commits at the coming edge
    assign retireValid  = !halted;
    assign regWriteEn   = u_bus.regWrite;
    assign regWriteAddr = u_bus.destReg;
    assign regWriteData = writeData;

endmodule

`default_nettype wire

/* procPkg.sv */
// Processor package with widths, memory depths, encodings, instruction fields and control types
`default_nettype none

package procPkg;

    localparam int dataWidth     = 16;
    localparam int regAddrWidth  = 3;
    localparam int numRegs       = 1 << regAddrWidth;
    localparam int imemDepth     = 256;
    localparam int dmemDepth     = 256;
    localparam int imemAddrWidth = $clog2(imemDepth);
    localparam int dmemAddrWidth = $clog2(dmemDepth);
    localparam string programFile = "program.hex";

    // Instruction fields opcode [15:11], rs [10:8], rt [7:5], rd [4:2] and func [1:0]
    localparam int opcodeWidth = 5;
    localparam int opcodeLsb   = 11;
    localparam int rsLsb       = 8;
    localparam int rtLsb       = 5;
    localparam int rdLsb       = 2;

    typedef enum logic [opcodeWidth-1:0] {
        opHalt = 5'b00000,
        opAlu  = 5'b00001,
        opAddi = 5'b00010,
        opSeq  = 5'b00011,
        opSlt  = 5'b00100,
        opLd   = 5'b00101,
        opSt   = 5'b00110,
        opBeqz = 5'b00111,
        opBnez = 5'b01000,
        opJ    = 5'b01001,
        opJr   = 5'b01010
    } opcodeT;

    typedef enum logic [1:0] {
        funcAdd = 2'b00,
        funcSub = 2'b01,
        funcAnd = 2'b10,
        funcXor = 2'b11
    } aluFuncT;

    typedef enum logic [1:0] {
        pcSeq     = 2'b00,
        pcBranch  = 2'b01,
        pcJump    = 2'b10,
        pcJumpReg = 2'b11
    } nextPcSelT;

    // Control bundle built by decode for one instruction
    typedef struct packed {
        logic      useImm;
        aluFuncT   aluFunc;
        logic      setEq;
        logic      setLt;
        nextPcSelT nextPcSel;
        logic      branchOnZero;
        logic      memRead;
        logic      memWrite;
        logic      memToReg;
        logic      regWrite;
    } ctrlT;

    localparam ctrlT ctrlIdle = '{
        useImm: 1'b0, aluFunc: funcAdd, setEq: 1'b0, setLt: 1'b0,
        nextPcSel: pcSeq, branchOnZero: 1'b0, memRead: 1'b0,
        memWrite: 1'b0, memToReg: 1'b0, regWrite: 1'b0
    };

    // Sign-extended immediate whose width depends on the opcode
    function automatic logic [dataWidth-1:0] immOf(input logic [dataWidth-1:0] instr);
        opcodeT op;
        op = opcodeT'(instr[opcodeLsb +: opcodeWidth]);
        case (op)
            opAddi, opLd, opSt: immOf = {{(dataWidth-5){instr[4]}}, instr[4:0]};
            opBeqz, opBnez:     immOf = {{(dataWidth-8){instr[7]}}, instr[7:0]};
            opJ:                immOf = {{(dataWidth-11){instr[10]}}, instr[10:0]};
            default:            immOf = '0;
        endcase
    endfunction

endpackage

`default_nettype wire

/* procTb.sv */
// Testbench for proc with instruction-set model, halt wait and checking assertions
`timescale 1ns/1ps
`default_nettype none

module procTb;
    import procPkg::*;

    logic                    clk;
    logic                    rstN;
    logic                    err;
    logic                    halted;
    logic                    retireValid;
    logic                    regWriteEn;
    logic [regAddrWidth-1:0] regWriteAddr;
    logic [dataWidth-1:0]    regWriteData;
    logic                    memWriteEn;
    logic [dataWidth-1:0]    memAddr;
    logic [dataWidth-1:0]    memWriteData;

    // Model state
    logic [dataWidth-1:0]    progMem [imemDepth];
    logic [dataWidth-1:0]    modelRegs [numRegs];
    logic [dataWidth-1:0]    modelMem [dmemDepth];
    logic [dataWidth-1:0]    modelPc;
    logic                    modelHalted;

    // Model prediction for the instruction at modelPc
    logic [dataWidth-1:0]    curInstr;
    opcodeT                  curOp;
    logic [dataWidth-1:0]    srcA;
    logic [dataWidth-1:0]    srcB;
    logic [dataWidth-1:0]    immI;
    logic [dataWidth-1:0]    immB;
    logic [dataWidth-1:0]    immJ;
    logic [dataWidth-1:0]    seqPc;
    logic                    expRegWe;
    logic [regAddrWidth-1:0] expRegAddr;
    logic [dataWidth-1:0]    expRegData;
    logic                    expMemWe;
    logic [dataWidth-1:0]    expMemAddr;
    logic [dataWidth-1:0]    expMemData;
    logic [dataWidth-1:0]    expNextPc;
    logic                    expHalt;
    logic                    expErr;
    int                      cycles;

    tbClockGen u_clockGen (
        .clk  (clk),
        .rstN (rstN)
    );

    proc u_proc (
        .clk          (clk),
        .rstN         (rstN),
        .err          (err),
        .halted       (halted),
        .retireValid  (retireValid),
        .regWriteEn   (regWriteEn),
        .regWriteAddr (regWriteAddr),
        .regWriteData (regWriteData),
        .memWriteEn   (memWriteEn),
        .memAddr      (memAddr),
        .memWriteData (memWriteData)
    );

    task automatic stopWithFailure();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic [dataWidth-1:0] expected,
                                  input logic [dataWidth-1:0] actual);
        $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
        stopWithFailure();
    endtask

    initial begin
        $readmemh(programFile, progMem);
    end

    // Field positions follow the instruction format of the package
    always_comb begin
        curInstr   = progMem[modelPc[imemAddrWidth-1:0]];
        curOp      = opcodeT'(curInstr[opcodeLsb +: opcodeWidth]);
        srcA       = modelRegs[curInstr[rsLsb +: regAddrWidth]];
        srcB       = modelRegs[curInstr[rtLsb +: regAddrWidth]];
        immI       = {{(dataWidth-5){curInstr[4]}}, curInstr[4:0]};
        immB       = {{(dataWidth-8){curInstr[7]}}, curInstr[7:0]};
        immJ       = {{(dataWidth-11){curInstr[10]}}, curInstr[10:0]};
        seqPc      = modelPc + dataWidth'(1);
        expRegWe   = 1'b0;
        expRegAddr = curInstr[rdLsb +: regAddrWidth];
        expRegData = '0;
        expMemWe   = 1'b0;
        expMemAddr = srcA + immI;
        expMemData = srcB;
        expNextPc  = seqPc;
        expHalt    = 1'b0;
        expErr     = 1'b0;
        case (curOp)
            opAlu: begin
                expRegWe = 1'b1;
                case (aluFuncT'(curInstr[1:0]))
                    funcAdd: expRegData = srcA + srcB;
                    funcSub: expRegData = srcA - srcB;
                    funcAnd: expRegData = srcA & srcB;
                    default: expRegData = srcA ^ srcB;
                endcase
            end
            opAddi: begin
                expRegWe   = 1'b1;
                expRegAddr = curInstr[rtLsb +: regAddrWidth];
                expRegData = srcA + immI;
            end
            opSeq: begin
                expRegWe   = 1'b1;
                expRegData = dataWidth'(srcA == srcB);
            end
            opSlt: begin
                expRegWe   = 1'b1;
                expRegData = dataWidth'($signed(srcA) < $signed(srcB));
            end
            opLd: begin
                expRegWe   = 1'b1;
                expRegAddr = curInstr[rtLsb +: regAddrWidth];
                expRegData = modelMem[expMemAddr[dmemAddrWidth-1:0]];
            end
            opSt:    expMemWe = 1'b1;
            opBeqz:  expNextPc = (srcA == '0) ? seqPc + immB : seqPc;
            opBnez:  expNextPc = (srcA != '0) ? seqPc + immB : seqPc;
            opJ:     expNextPc = seqPc + immJ;
            opJr:    expNextPc = srcA;
            opHalt:  expHalt = 1'b1;
            default: expErr = 1'b1;
        endcase
        if (expErr || modelHalted) begin
            expRegWe = 1'b0;
            expMemWe = 1'b0;
            expHalt  = 1'b0;
        end
        if (modelHalted) begin
            expErr = 1'b0;
        end
    end

    // Model commits at the same edge as the DUT
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            modelPc     <= '0;
            modelHalted <= 1'b0;
            for (int i = 0; i < numRegs; i++) begin
                modelRegs[i] <= '0;
            end
            for (int i = 0; i < dmemDepth; i++) begin
                modelMem[i] <= '0;
            end
        end else if (!modelHalted) begin
            if (expRegWe) begin
                modelRegs[expRegAddr] <= expRegData;
            end
            if (expMemWe) begin
                modelMem[expMemAddr[dmemAddrWidth-1:0]] <= expMemData;
            end
            if (expHalt) begin
                modelHalted <= 1'b1;
            end else begin
                modelPc <= expNextPc;
            end
        end
    end

    // Quiet outputs while reset is held
    assert property (@(posedge clk) !rstN |-> !err)
        else reportMismatch("err", '0, dataWidth'($sampled(err)));
    assert property (@(posedge clk) !rstN |-> !regWriteEn)
        else reportMismatch("regWriteEn", '0, dataWidth'($sampled(regWriteEn)));
    assert property (@(posedge clk) !rstN |-> !memWriteEn)
        else reportMismatch("memWriteEn", '0, dataWidth'($sampled(memWriteEn)));

    assert property (@(posedge clk) disable iff (!rstN) err == expErr)
        else reportMismatch("err", dataWidth'($sampled(expErr)), dataWidth'($sampled(err)));
    assert property (@(posedge clk) disable iff (!rstN) halted == modelHalted)
        else reportMismatch("halted", dataWidth'($sampled(modelHalted)),
                            dataWidth'($sampled(halted)));
    assert property (@(posedge clk) disable iff (!rstN) retireValid == !modelHalted)
        else reportMismatch("retireValid", dataWidth'(!$sampled(modelHalted)),
                            dataWidth'($sampled(retireValid)));

    // Register write trace
    assert property (@(posedge clk) disable iff (!rstN) regWriteEn == expRegWe)
        else reportMismatch("regWriteEn", dataWidth'($sampled(expRegWe)),
                            dataWidth'($sampled(regWriteEn)));
    assert property (@(posedge clk) disable iff (!rstN) expRegWe |-> regWriteAddr == expRegAddr)
        else reportMismatch("regWriteAddr", dataWidth'($sampled(expRegAddr)),
                            dataWidth'($sampled(regWriteAddr)));
    assert property (@(posedge clk) disable iff (!rstN) expRegWe |-> regWriteData == expRegData)
        else reportMismatch("regWriteData", $sampled(expRegData), $sampled(regWriteData));

    // Store trace
    assert property (@(posedge clk) disable iff (!rstN) memWriteEn == expMemWe)
        else reportMismatch("memWriteEn", dataWidth'($sampled(expMemWe)),
                            dataWidth'($sampled(memWriteEn)));
    assert property (@(posedge clk) disable iff (!rstN) expMemWe |-> memAddr == expMemAddr)
        else reportMismatch("memAddr", $sampled(expMemAddr), $sampled(memAddr));
    assert property (@(posedge clk) disable iff (!rstN) expMemWe |-> memWriteData == expMemData)
        else reportMismatch("memWriteData", $sampled(expMemData), $sampled(memWriteData));

    initial begin
        cycles = 0;
        while (halted !== 1'b1 && cycles < 500) begin
            @(negedge clk);
            cycles++;
        end
        if (halted !== 1'b1) begin
            $display("Timeout: the processor did not halt within 500 cycles");
            stopWithFailure();
        end else begin
            // Nothing may commit while halted
            repeat (20) @(negedge clk);
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* program.hex */
// One 16-bit instruction word per line, word address 0 upwards
// Fields: opcode [15:11], rs [10:8], rt [7:5], rd [4:2] or immediate, func [1:0]
4800
1025
105D
094C
0951
0956
095B
19BC
222C
31C2
2887
3801
1121
4005
4101
1121
3902
10AF
15A6
5500
1121
4801
1121
3060
2840
0000
F800

/* run.sh */
#!/usr/bin/env bash
# Build and run the proc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module procTb -Mdir obj_dir > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/VprocTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Done: no errors" sim.log; then
    exit 0
else
    exit 1
fi

/* sim.f */
procPkg.sv
execBus.sv
fetch.sv
decode.sv
execute.sv
memoryStage.sv
proc.sv
tbClockGen.sv
procTb.sv

/* tbClockGen.sv */
// Testbench clock and reset generator
`timescale 1ns/1ps
`default_nettype none

module tbClockGen (
    output logic clk,
    output logic rstN
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held for two rising edges and released just after the second
    initial begin
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        #10;
        rstN = 1'b1;
    end

endmodule

`default_nettype wire
